/* dv/lcd_tb.sv */
// testbench for the lcd video back end
// plays source lines from the tests file, checks hsync, vsync and colour output
`include "lcd_params.svh"

module lcd_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import lcd_pkg::*;

	localparam int VBL_LINES = 10;
	localparam int MAX_TESTS = 32;
	localparam int V_RELOAD  = `LCD_V + `LCD_VFP + `LCD_VS + `LCD_VBP - `LCD_VSYNC_OFFSET;
	localparam int V_TOTAL   = `LCD_V + `LCD_VFP + `LCD_VS + `LCD_VBP;
	localparam int H_TOTAL   = `LCD_H + `LCD_HFP + `LCD_HS + `LCD_HBP;

	logic      clk64;
	logic      arst_n;
	logic      clkena;
	pixel_t    data;
	lcd_mode_e mode;
	logic      tint;
	logic      pclk_en;
	logic      on;
	logic      hs;
	logic      vs;
	chan_t     r;
	chan_t     g;
	chan_t     b;

	// test records
	int          n_tests;
	int          t_tint [MAX_TESTS];
	int          t_on [MAX_TESTS];
	logic [31:0] t_seed [MAX_TESTS];
	int          t_lines [MAX_TESTS];
	int          total_lines;
	bit          loaded;

	// source and display model
	logic [31:0] rng;
	pixel_t      bank_mem [2][256];
	bit          bank_ok [2][256];
	bit          bank;
	int          wcol;
	int          v_exp;
	bit          prev_vblank;
	bit          first_line;
	bit          checks_on;

	lcd_video_top dut0 (
		.clk64(clk64), .arst_n(arst_n), .clkena(clkena), .data(data), .mode(mode),
		.tint(tint), .pclk_en(pclk_en), .on(on), .hs(hs), .vs(vs), .r(r), .g(g), .b(b)
	);

	initial clk64 = 1'b0;
	always #4 clk64 = ~clk64;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// palette tables, ch 0 red, 1 green, 2 blue
	function automatic chan_t colour_of(input int ch, input logic tnt, input pixel_t p);
		chan_t tr [4];
		chan_t tg [4];
		chan_t tb [4];
		chan_t grey [4];
		tr   = '{6'd39, 6'd32, 6'd12, 6'd7};
		tg   = '{6'd47, 6'd40, 6'd25, 6'd4};
		tb   = '{6'd4, 6'd2, 6'd12, 6'd4};
		grey = '{6'd63, 6'd42, 6'd24, 6'd0};
		if (!tnt) begin
			return grey[p];
		end
		return (ch == 0) ? tr[p] : ((ch == 1) ? tg[p] : tb[p]);
	endfunction

	task automatic report_mismatch(input string name, input logic [7:0] exp, input logic [7:0] got);
		$display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, got);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	// outputs after the strobe edge of line position j
	task automatic check_outputs(input int j);
		int     col;
		bit     known;
		pixel_t shade;
		chan_t  er;
		chan_t  eg;
		chan_t  eb;
		logic   ehs;
		logic   evs;
		ehs = !(j >= `LCD_H + `LCD_HFP + 1 && j <= `LCD_H + `LCD_HFP + `LCD_HS);
		evs = (v_exp >= `LCD_V + `LCD_VFP) && (v_exp < `LCD_V + `LCD_VFP + `LCD_VS);
		assert (hs === ehs) else report_mismatch("hs", 8'(ehs), 8'(hs));
		assert (vs === evs) else report_mismatch("vs", 8'(evs), 8'(vs));
		known = 1'b1;
		er = '0;
		eg = '0;
		eb = '0;
		// two strobe latency from h_count to colour
		if (j >= 2 && j < 2 + `LCD_H && v_exp < `LCD_V) begin
			col   = j - 2;
			known = !on || bank_ok[!bank][col];
			shade = on ? bank_mem[!bank][col] : 2'd0;
			er    = colour_of(0, tint, shade);
			eg    = colour_of(1, tint, shade);
			eb    = colour_of(2, tint, shade);
		end
		if (known) begin
			assert (r === er) else report_mismatch("r", 8'(er), 8'(r));
			assert (g === eg) else report_mismatch("g", 8'(eg), 8'(g));
			assert (b === eb) else report_mismatch("b", 8'(eb), 8'(b));
		end
	endtask

	task automatic write_pixel(input bit wr);
		clkena = wr;
		if (wr) begin
			rng  = xorshift(rng);
			data = rng[1:0];
			bank_mem[bank][wcol % 256] = rng[1:0];
			bank_ok[bank][wcol % 256]  = 1'b1;
			wcol++;
		end
	endtask

	// one pixel strobe, two clk64 cycles
	task automatic play_strobe(input lcd_mode_e m, input bit wr, input int j);
		mode    = m;
		pclk_en = 1'b1;
		write_pixel(wr);
		@(posedge clk64);
		#1;
		if (checks_on) begin
			check_outputs(j);
		end
		pclk_en = 1'b0;
		write_pixel(wr);
		@(posedge clk64);
		#1;
	endtask

	// active: oam, xfer with 160 writes, hblank; else vblank then hblank
	task automatic play_line(input bit active);
		lcd_mode_e m;
		bank = !bank;
		wcol = 0;
		if (!first_line) begin
			if (active && prev_vblank) begin
				v_exp = V_RELOAD;
			end else begin
				v_exp = (v_exp == V_TOTAL - 1) ? 0 : v_exp + 1;
			end
		end
		prev_vblank = !active;
		first_line  = 1'b0;
		for (int j = 0; j < H_TOTAL; j++) begin
			if (active) begin
				m = (j < 20) ? MODE_OAM : ((j < 100) ? MODE_XFER : MODE_HBLANK);
			end else begin
				m = (j < 100) ? MODE_VBLANK : MODE_HBLANK;
			end
			play_strobe(m, active && j >= 20 && j < 100, j);
		end
	endtask

	// ----------------------------------------------------------------------
	// watchdog
	// ----------------------------------------------------------------------
	initial begin
		wait (loaded);
		#((total_lines + 20) * H_TOTAL * 2 * 8);
		$display("ERROR: simulation timed out before all test lines were played");
		$display("FAIL: see errors above");
		$fatal(1);
	end

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		int    fd;
		int    a;
		int    c;
		int    d;
		logic [31:0] s;
		string line;
		arst_n      = 1'b0;
		clkena      = 1'b0;
		data        = '0;
		mode        = MODE_HBLANK;
		tint        = 1'b0;
		pclk_en     = 1'b0;
		on          = 1'b1;
		rng         = 32'd4293;
		bank        = 1'b0;
		v_exp       = 0;
		prev_vblank = 1'b0;
		first_line  = 1'b1;
		checks_on   = 1'b0;
		n_tests     = 0;
		total_lines = 1;
		fd = $fopen("dv/lcd_tests.txt", "r");
		if (fd == 0) begin
			$display("ERROR: could not open the tests file dv/lcd_tests.txt");
			$display("FAIL: see errors above");
			$fatal(1);
		end
		while (!$feof(fd) && n_tests < MAX_TESTS) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#") begin
				continue;
			end
			if ($sscanf(line, "%d %d %h %d", a, c, s, d) == 4) begin
				t_tint[n_tests]  = a;
				t_on[n_tests]    = c;
				t_seed[n_tests]  = s;
				t_lines[n_tests] = d;
				total_lines += VBL_LINES + d;
				n_tests++;
			end
		end
		$fclose(fd);
		loaded = 1'b1;
		repeat (5) @(posedge clk64);
		#1;
		arst_n = 1'b1;
		// first oam edge locks h_count
		play_line(1'b1);
		checks_on = 1'b1;
		for (int t = 0; t < n_tests; t++) begin
			tint = t_tint[t][0];
			on   = t_on[t][0];
			rng  = xorshift(rng ^ t_seed[t]);
			if (rng == 0) begin
				rng = 32'd4293;
			end
			repeat (VBL_LINES) play_line(1'b0);
			repeat (t_lines[t]) play_line(1'b1);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* dv/lcd_tests.txt */
# tint on seed(hex) lines
# tint selects green palette, on clear forces shade 0
0 1 00001a2b 8
1 1 00003c4d 8
0 0 00005e6f 6
1 0 00007081 6
0 1 000092a3 590
1 1 0000b4c5 6

/* rtl/lcd_line_buffer.sv */
// lcd line buffer
// two banks of 256 pixels, source writes one while the scan reads the other
module lcd_line_buffer (
	input  logic                clk64,
	input  logic                arst_n,
	input  logic                clkena,
	input  lcd_pkg::pixel_t     data,
	input  logic                rd_en,
	input  lcd_pkg::line_addr_t rd_addr,
	lcd_sync_if.linebuf         sync,
	output lcd_pkg::pixel_t     rd_pixel
);
	import lcd_pkg::*;

	// bank select is the top address bit
	pixel_t mem [0:511];

	line_addr_t wr_col;

	// ----------------------------------------------------------------------
	// write column
	// ----------------------------------------------------------------------
	always_ff @(posedge clk64 or negedge arst_n) begin
		if (!arst_n) begin
			wr_col <= '0;
		end else if (sync.wr_restart) begin
			// new line from the source
			wr_col <= '0;
		end else if (clkena) begin
			// past 255 simply wraps inside the bank
			wr_col <= wr_col + 8'd1;
		end
	end

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	always_ff @(posedge clk64) begin
		if (clkena) begin
			mem[{sync.bank, wr_col}] <= data;
		end
	end

	// read always from the bank not being written
	// data one clk64 after rd_en
	always_ff @(posedge clk64) begin
		if (rd_en) begin
			rd_pixel <= mem[{~sync.bank, rd_addr}];
		end
	end

endmodule

/* rtl/lcd_mode_decode.sv */
// lcd mode decoder
// turns mode code transitions into line, bank and frame events
module lcd_mode_decode (
	input  logic              clk64,
	input  logic              arst_n,
	input  logic              pclk_en,
	input  lcd_pkg::lcd_mode_e mode,
	input  logic              line_end,
	lcd_sync_if.driver        sync
);
	import lcd_pkg::*;

	// previous mode, write side sees every clk64
	lcd_mode_e last_mode_w;
	// previous mode per pixel strobe and per end of line
	lcd_mode_e last_mode_h;
	lcd_mode_e last_mode_v;

	logic wr_restart_q;
	logic bank_q;
	logic leave_hblank;

	// ----------------------------------------------------------------------
	// write side
	// ----------------------------------------------------------------------
	assign leave_hblank = (mode != MODE_HBLANK) && (last_mode_w == MODE_HBLANK);

	always_ff @(posedge clk64 or negedge arst_n) begin
		if (!arst_n) begin
			last_mode_w  <= MODE_HBLANK;
			wr_restart_q <= 1'b0;
			bank_q       <= 1'b0;
		end else begin
			last_mode_w  <= mode;
			wr_restart_q <= leave_hblank;
			// swap banks, finished line becomes readable
			if (leave_hblank) begin
				bank_q <= ~bank_q;
			end
		end
	end

	// ----------------------------------------------------------------------
	// scan side
	// ----------------------------------------------------------------------
	always_ff @(posedge clk64 or negedge arst_n) begin
		if (!arst_n) begin
			last_mode_h <= MODE_HBLANK;
			last_mode_v <= MODE_HBLANK;
		end else if (pclk_en) begin
			last_mode_h <= mode;
			// vblank exit is only judged once per line
			if (line_end) begin
				last_mode_v <= mode;
			end
		end
	end

	assign sync.wr_restart = wr_restart_q;
	assign sync.bank       = bank_q;
	// end of hblank, restart the horizontal count
	assign sync.line_sync  = pclk_en && (mode == MODE_OAM) && (last_mode_h == MODE_HBLANK);
	// end of vblank
	assign sync.frame_sync = pclk_en && line_end && (mode != MODE_VBLANK) &&
		(last_mode_v == MODE_VBLANK);

	// restart pulse and bank swap never come apart
	a_restart_bank : assert property (
		@(posedge clk64) disable iff (!arst_n)
		wr_restart_q == (bank_q != $past(bank_q))
	);

endmodule

/* rtl/lcd_palette.sv */
// lcd palette stage
// maps 2-bit shades to rgb through grey or tinted green tables, with blanking
module lcd_palette (
	input  logic            clk64,
	input  logic            arst_n,
	input  logic            pclk_en,
	input  logic            visible,
	input  lcd_pkg::pixel_t pixel,
	input  logic            on,
	input  logic            tint,
	output lcd_pkg::chan_t  r,
	output lcd_pkg::chan_t  g,
	output lcd_pkg::chan_t  b
);
	import lcd_pkg::*;

	// colour tables, index is the shade
	localparam chan_t GREY   [4] = '{6'd63, 6'd42, 6'd24, 6'd0};
	localparam chan_t TINT_R [4] = '{6'd39, 6'd32, 6'd12, 6'd7};
	localparam chan_t TINT_G [4] = '{6'd47, 6'd40, 6'd25, 6'd4};
	localparam chan_t TINT_B [4] = '{6'd4, 6'd2, 6'd12, 6'd4};

	pixel_t pix_q;
	logic   blank_q;
	pixel_t shade;

	// one stage behind the buffer read
	always_ff @(posedge clk64 or negedge arst_n) begin
		if (!arst_n) begin
			pix_q   <= '0;
			blank_q <= 1'b1;
		end else if (pclk_en) begin
			pix_q   <= pixel;
			blank_q <= ~visible;
		end
	end

	// panel off shows the lightest shade
	assign shade = on ? pix_q : 2'd0;

	always_comb begin
		if (blank_q) begin
			r = '0;
			g = '0;
			b = '0;
		end else if (tint) begin
			r = TINT_R[shade];
			g = TINT_G[shade];
			b = TINT_B[shade];
		end else begin
			r = GREY[shade];
			g = GREY[shade];
			b = GREY[shade];
		end
	end

endmodule

/* rtl/lcd_params.svh */
// lcd video timing constants
// output raster is 228 columns by 616 rows per frame
`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

// ----------------------------------------------------------------------
// horizontal, in pixel clock strobes
// ----------------------------------------------------------------------
`define LCD_H    160
`define LCD_HFP  24
`define LCD_HS   20
`define LCD_HBP  24

// ----------------------------------------------------------------------
// vertical, in lines
// ----------------------------------------------------------------------
`define LCD_V    576
`define LCD_VFP  2
`define LCD_VS   2
`define LCD_VBP  36

// rows before the wrap where v_count lands at end of vblank
`define LCD_VSYNC_OFFSET 4

`endif

/* rtl/lcd_pkg.sv */
// lcd video shared types
// mode code of the lcd controller plus pixel, colour and address types
package lcd_pkg;

	// mode code as sent by the lcd controller
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_XFER   = 2'd3
	} lcd_mode_e;

	// shade code, 0 is the lightest
	typedef logic [1:0] pixel_t;

	// one colour channel towards the dac
	typedef logic [5:0] chan_t;

	// column inside one line buffer bank
	typedef logic [7:0] line_addr_t;

endpackage

/* rtl/lcd_scan_timing.sv */
// lcd scan timing
// h and v counters locked to source mode events, syncs and read addressing
`include "lcd_params.svh"

module lcd_scan_timing (
	input  logic                clk64,
	input  logic                arst_n,
	input  logic                pclk_en,
	lcd_sync_if.scan            sync,
	output logic                line_end,
	output logic                hs,
	output logic                vs,
	output logic                rd_en,
	output lcd_pkg::line_addr_t rd_addr,
	output logic                visible
);
	import lcd_pkg::*;

	// horizontal points
	localparam logic [7:0] H_VIS  = 8'(`LCD_H);
	localparam logic [7:0] HS_ON  = 8'(`LCD_H + `LCD_HFP);
	localparam logic [7:0] HS_OFF = 8'(`LCD_H + `LCD_HFP + `LCD_HS);
	localparam logic [7:0] H_LAST = 8'(`LCD_H + `LCD_HFP + `LCD_HS + `LCD_HBP - 1);

	// vertical points
	localparam logic [9:0] V_VIS    = 10'(`LCD_V);
	localparam logic [9:0] VS_ON    = 10'(`LCD_V + `LCD_VFP);
	localparam logic [9:0] VS_OFF   = 10'(`LCD_V + `LCD_VFP + `LCD_VS);
	localparam logic [9:0] V_LAST   = 10'(`LCD_V + `LCD_VFP + `LCD_VS + `LCD_VBP - 1);
	localparam logic [9:0] V_RELOAD = 10'(`LCD_V + `LCD_VFP + `LCD_VS + `LCD_VBP -
		`LCD_VSYNC_OFFSET);

	logic [7:0] h_count;
	logic [9:0] v_count;
	logic [9:0] v_next;
	logic       in_window;

	assign line_end  = (h_count == H_LAST);
	assign in_window = (h_count < H_VIS) && (v_count < V_VIS);
	assign rd_en     = pclk_en && in_window;

	// ----------------------------------------------------------------------
	// horizontal
	// ----------------------------------------------------------------------
	always_ff @(posedge clk64 or negedge arst_n) begin
		if (!arst_n) begin
			h_count <= '0;
			hs      <= 1'b1;
		end else if (pclk_en) begin
			// oam after hblank pins the line start
			if (sync.line_sync || line_end) begin
				h_count <= '0;
			end else begin
				h_count <= h_count + 8'd1;
			end
			// negative hsync
			if (h_count == HS_ON) begin
				hs <= 1'b0;
			end
			if (h_count == HS_OFF) begin
				hs <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// vertical, steps once per line
	// ----------------------------------------------------------------------
	// vblank exit lands a few rows before the wrap
	always_comb begin
		if (sync.frame_sync) begin
			v_next = V_RELOAD;
		end else if (v_count == V_LAST) begin
			v_next = '0;
		end else begin
			v_next = v_count + 10'd1;
		end
	end

	always_ff @(posedge clk64 or negedge arst_n) begin
		if (!arst_n) begin
			v_count <= '0;
			vs      <= 1'b0;
		end else if (pclk_en && line_end) begin
			v_count <= v_next;
			// positive vsync, follows the row being entered
			if (v_next == VS_ON) begin
				vs <= 1'b1;
			end
			if (v_next == VS_OFF) begin
				vs <= 1'b0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// read side of the line buffer
	// ----------------------------------------------------------------------
	always_ff @(posedge clk64 or negedge arst_n) begin
		if (!arst_n) begin
			rd_addr <= '0;
			visible <= 1'b0;
		end else if (pclk_en) begin
			visible <= in_window;
			if (in_window) begin
				rd_addr <= rd_addr + 8'd1;
			end else begin
				rd_addr <= '0;
			end
		end
	end

	// hsync pulse is 20 strobes unless a resync cuts in
	a_hs_width : assert property (
		@(posedge clk64) disable iff (!arst_n || sync.line_sync)
		$fell(hs) |-> (!hs throughout (pclk_en [-> 20])) ##1 hs
	);

endmodule

/* rtl/lcd_sync_if.sv */
// mode events from the decoder
// feeds the line buffer write side and the scan counters
interface lcd_sync_if;

	// write column back to 0, mode just left hblank
	logic wr_restart;

	// bank being written now, toggles with wr_restart
	logic bank;

	// hblank to oam seen on a pixel strobe
	logic line_sync;

	// first end of line strobe after vblank
	logic frame_sync;

	// decoder side
	modport driver (
		output wr_restart,
		output bank,
		output line_sync,
		output frame_sync
	);

	// line buffer side
	modport linebuf (
		input wr_restart,
		input bank
	);

	// scan timing side
	modport scan (
		input bank,
		input line_sync,
		input frame_sync
	);

endinterface

/* rtl/lcd_video_top.sv */
// lcd video back end
// line buffer, regenerated scan timing and palette for an lcd pixel stream
module lcd_video_top (
	input  logic               clk64,
	input  logic               arst_n,
	input  logic               clkena,
	input  lcd_pkg::pixel_t    data,
	input  lcd_pkg::lcd_mode_e mode,
	input  logic               tint,
	input  logic               pclk_en,
	input  logic               on,
	output logic               hs,
	output logic               vs,
	output lcd_pkg::chan_t     r,
	output lcd_pkg::chan_t     g,
	output lcd_pkg::chan_t     b
);
	import lcd_pkg::*;

	lcd_sync_if sync_if ();

	logic       line_end;
	logic       rd_en;
	line_addr_t rd_addr;
	pixel_t     rd_pixel;
	logic       visible;

	// decode
	lcd_mode_decode u_decode (
		.clk64    (clk64),
		.arst_n   (arst_n),
		.pclk_en  (pclk_en),
		.mode     (mode),
		.line_end (line_end),
		.sync     (sync_if.driver)
	);

	// execute
	lcd_scan_timing u_scan (
		.clk64    (clk64),
		.arst_n   (arst_n),
		.pclk_en  (pclk_en),
		.sync     (sync_if.scan),
		.line_end (line_end),
		.hs       (hs),
		.vs       (vs),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.visible  (visible)
	);

	lcd_line_buffer u_buf (
		.clk64    (clk64),
		.arst_n   (arst_n),
		.clkena   (clkena),
		.data     (data),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.sync     (sync_if.linebuf),
		.rd_pixel (rd_pixel)
	);

	// result
	lcd_palette u_palette (
		.clk64    (clk64),
		.arst_n   (arst_n),
		.pclk_en  (pclk_en),
		.visible  (visible),
		.pixel    (rd_pixel),
		.on       (on),
		.tint     (tint),
		.r        (r),
		.g        (g),
		.b        (b)
	);

endmodule

/* run.sh */
#!/bin/sh
# build and run the lcd video testbench with verilator

verilator --binary --timing --assert -f verilog.f --top-module lcd_tb \
	-Mdir obj_dir -o lcd_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

(./obj_dir/lcd_sim > sim.log 2>&1 || true) && \
	grep -q "^PASS: all tests$" sim.log && echo "simulation passed" || \
	{ echo "simulation failed, see sim.log"; exit 1; }

/* verilog.f */
+incdir+rtl
rtl/lcd_pkg.sv
rtl/lcd_sync_if.sv
rtl/lcd_mode_decode.sv
rtl/lcd_line_buffer.sv
rtl/lcd_scan_timing.sv
rtl/lcd_palette.sv
rtl/lcd_video_top.sv
dv/lcd_tb.sv
